// ==== verilog/controlPkg.sv ====
package controlPkg;

  localparam int instrWidth = 32;

  // Primary opcodes handled by the unit
  typedef enum logic [5:0] {
    opRType  = 6'b000000,
    opRegimm = 6'b000001,
    opJ      = 6'b000010,
    opJal    = 6'b000011,
    opBeq    = 6'b000100,
    opBne    = 6'b000101,
    opBlez   = 6'b000110,
    opBgtz   = 6'b000111,
    opAddiu  = 6'b001001,
    opSlti   = 6'b001010,
    opAndi   = 6'b001100,
    opOri    = 6'b001101,
    opXori   = 6'b001110,
    opLui    = 6'b001111,
    opLb     = 6'b100000,
    opLh     = 6'b100001,
    opLw     = 6'b100011,
    opLbu    = 6'b100100,
    opLhu    = 6'b100101,
    opSw     = 6'b101011
  } opcodeT;

  typedef enum logic [5:0] {
    fnJr   = 6'b001000,
    fnJalr = 6'b001001
  } functT;

  // rt field of the REGIMM group
  typedef enum logic [4:0] {
    rtBltz = 5'b00000,
    rtBgez = 5'b00001
  } regimmT;

  typedef enum logic [2:0] {
    fetchS  = 3'b000,
    decodeS = 3'b001,
    exec1S  = 3'b010,
    exec2S  = 3'b011,
    exec3S  = 3'b100,
    haltedS = 3'b101,
    stallS  = 3'b110
  } cpuStateT;

  // Codes understood by the datapath ALU
  typedef enum logic [4:0] {
    aluAnd          = 5'b00000,
    aluOr           = 5'b00001,
    aluAdd          = 5'b00010,
    aluXor          = 5'b00011,
    aluSlt          = 5'b00111,
    aluEq           = 5'b01010,
    aluPassB        = 5'b01011,
    aluSignTest     = 5'b01100,
    aluBranchTarget = 5'b01101,
    aluPassA        = 5'b01110,
    aluFunct        = 5'b01111,
    aluGtz          = 5'b10000,
    aluJumpTarget   = 5'b10001,
    aluLui          = 5'b10100
  } aluOpT;

  typedef enum logic [3:0] {
    clsAluReg, clsJr, clsJalr, clsLoad, clsStore, clsAluImm,
    clsLui, clsBranch, clsJ, clsJal, clsNop
  } instrClassT;

  typedef enum logic [2:0] {brEq, brNe, brGtz, brLez, brLtz, brGez} branchKindT;

  typedef enum logic [1:0] {sizeWord, sizeHalf, sizeByte} accessSizeT;

  typedef enum logic [1:0] {
    extNone     = 2'b00,
    extSignByte = 2'b10,
    extSignHalf = 2'b11
  } memExtT;

endpackage

// ==== verilog/instrClassifier.sv ====
`timescale 1ns/100ps

module instrClassifier (
  input  logic [controlPkg::instrWidth-1:0] instr,
  output controlPkg::instrClassT            instrClass,
  output logic [1:0]                        execCycles,
  output controlPkg::branchKindT            branchKind,
  output controlPkg::aluOpT                 immAluOp,
  output logic                              zeroExtend,
  output controlPkg::accessSizeT            accessSize,
  output logic                              signedLoad
);
  import controlPkg::*;

  opcodeT opcode;
  functT  funct;
  regimmT rtCode;

  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = functT'(instr[5:0]);
  assign rtCode = regimmT'(instr[20:16]);

  always_comb begin
    instrClass = clsNop;
    branchKind = brEq;
    immAluOp   = aluAdd;
    zeroExtend = 1'b0;
    accessSize = sizeWord;
    signedLoad = 1'b0;
    case (opcode)
      opRType: begin
        if (funct == fnJr) begin
          instrClass = clsJr;
        end else if (funct == fnJalr) begin
          instrClass = clsJalr;
        end else begin
          instrClass = clsAluReg;
        end
      end
      // Linking forms of REGIMM fall through as no-ops
      opRegimm: begin
        immAluOp = aluSignTest;
        if (rtCode == rtBltz) begin
          instrClass = clsBranch;
          branchKind = brLtz;
        end else if (rtCode == rtBgez) begin
          instrClass = clsBranch;
          branchKind = brGez;
        end
      end
      opBeq: begin
        instrClass = clsBranch;
        branchKind = brEq;
        immAluOp   = aluEq;
      end
      opBne: begin
        instrClass = clsBranch;
        branchKind = brNe;
        immAluOp   = aluEq;
      end
      opBgtz: begin
        instrClass = clsBranch;
        branchKind = brGtz;
        immAluOp   = aluGtz;
      end
      opBlez: begin
        instrClass = clsBranch;
        branchKind = brLez;
        immAluOp   = aluGtz;
      end
      opJ:     instrClass = clsJ;
      opJal:   instrClass = clsJal;
      opAddiu: instrClass = clsAluImm;
      opSlti: begin
        instrClass = clsAluImm;
        immAluOp   = aluSlt;
      end
      // Logical immediates take a zero-extended operand
      opAndi: begin
        instrClass = clsAluImm;
        immAluOp   = aluAnd;
        zeroExtend = 1'b1;
      end
      opOri: begin
        instrClass = clsAluImm;
        immAluOp   = aluOr;
        zeroExtend = 1'b1;
      end
      opXori: begin
        instrClass = clsAluImm;
        immAluOp   = aluXor;
        zeroExtend = 1'b1;
      end
      opLui: begin
        instrClass = clsLui;
        immAluOp   = aluLui;
      end
      opLw:  instrClass = clsLoad;
      opLh: begin
        instrClass = clsLoad;
        accessSize = sizeHalf;
        signedLoad = 1'b1;
      end
      opLhu: begin
        instrClass = clsLoad;
        accessSize = sizeHalf;
      end
      opLb: begin
        instrClass = clsLoad;
        accessSize = sizeByte;
        signedLoad = 1'b1;
      end
      opLbu: begin
        instrClass = clsLoad;
        accessSize = sizeByte;
      end
      opSw:    instrClass = clsStore;
      default: instrClass = clsNop;
    endcase
  end

  // Execute cycles per class
  always_comb begin
    case (instrClass)
      clsLoad: execCycles = 2'd3;
      clsAluReg, clsJalr, clsStore, clsAluImm, clsLui, clsJal: execCycles = 2'd2;
      default: execCycles = 2'd1;
    endcase
  end

endmodule

// ==== verilog/cycleSequencer.sv ====
`timescale 1ns/100ps

module cycleSequencer (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   run,
  input  logic                   pcIsZero,
  input  logic                   waitRequest,
  input  logic                   outLsb,
  input  logic                   lessThan,
  input  controlPkg::instrClassT instrClass,
  input  logic [1:0]             execCycles,
  input  controlPkg::branchKindT branchKind,
  output controlPkg::cpuStateT   cpuState,
  output logic                   branchDelay
);
  import controlPkg::*;

  cpuStateT nextState;
  logic     branchTaken;
  logic     redirect;
  logic     leavingExec;

  // Condition from the ALU flags of the compare cycle
  always_comb begin
    case (branchKind)
      brEq:    branchTaken = outLsb;
      brNe:    branchTaken = ~outLsb;
      brGtz:   branchTaken = ~outLsb;
      brLez:   branchTaken = outLsb;
      brLtz:   branchTaken = lessThan;
      brGez:   branchTaken = ~lessThan;
      default: branchTaken = 1'b0;
    endcase
  end

  assign redirect = (instrClass inside {clsJ, clsJal, clsJr, clsJalr}) ||
                    (instrClass == clsBranch && branchTaken);

  always_comb begin
    nextState = cpuState;
    if (cpuState != haltedS && pcIsZero) begin
      nextState = haltedS;
    end else begin
      case (cpuState)
        fetchS, stallS: nextState = waitRequest ? stallS : decodeS;
        decodeS:        nextState = exec1S;
        exec1S:         nextState = (execCycles > 2'd1) ? exec2S : fetchS;
        exec2S: begin
          if (waitRequest) begin
            nextState = exec2S;
          end else begin
            nextState = (execCycles == 2'd3) ? exec3S : fetchS;
          end
        end
        exec3S:         nextState = fetchS;
        haltedS:        nextState = run ? fetchS : haltedS;
        default:        nextState = haltedS;
      endcase
    end
  end

  // Last execute cycle handing back to fetch
  assign leavingExec = (nextState == fetchS) && (cpuState inside {exec1S, exec2S, exec3S});

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cpuState    <= haltedS;
      branchDelay <= 1'b0;
    end else begin
      cpuState <= nextState;
      if (cpuState == haltedS && run) begin
        branchDelay <= 1'b0;
      end else if (leavingExec) begin
        branchDelay <= redirect;
      end
    end
  end

endmodule

// ==== verilog/controlSignalGen.sv ====
`timescale 1ns/100ps

module controlSignalGen (
  input  controlPkg::cpuStateT   cpuState,
  input  logic                   branchDelay,
  input  controlPkg::instrClassT instrClass,
  input  controlPkg::aluOpT      immAluOp,
  input  logic                   zeroExtend,
  input  controlPkg::accessSizeT accessSize,
  input  logic                   signedLoad,
  output logic                   extSel,
  output logic                   irSel,
  output logic                   iorD,
  output logic                   aluSrcA,
  output logic [1:0]             aluSrcB,
  output controlPkg::aluOpT      aluControl,
  output logic                   aluSel,
  output logic                   irWrite,
  output logic                   pcWrite,
  output logic                   regWrite,
  output logic                   memToReg,
  output logic                   pcSrc,
  output logic                   regDst,
  output logic                   memWrite,
  output logic                   memRead,
  output logic                   isJump,
  output logic                   link,
  output logic [3:0]             byteEnable,
  output controlPkg::memExtT     extendedMem,
  output logic                   active
);
  import controlPkg::*;

  logic [3:0] sizeMask;
  memExtT     loadExt;

  always_comb begin
    case (accessSize)
      sizeHalf: sizeMask = 4'b0011;
      sizeByte: sizeMask = 4'b0001;
      default:  sizeMask = 4'b1111;
    endcase
  end

  // Only signed sub-word loads need the extender
  always_comb begin
    loadExt = extNone;
    if (signedLoad && accessSize == sizeHalf) begin
      loadExt = extSignHalf;
    end else if (signedLoad && accessSize == sizeByte) begin
      loadExt = extSignByte;
    end
  end

  assign active = (cpuState != haltedS);

  always_comb begin
    extSel      = 1'b0;
    irSel       = 1'b1;
    iorD        = 1'b0;
    aluSrcA     = 1'b0;
    aluSrcB     = 2'b00;
    aluControl  = aluAdd;
    aluSel      = 1'b0;
    irWrite     = 1'b0;
    pcWrite     = 1'b0;
    regWrite    = 1'b0;
    memToReg    = 1'b0;
    pcSrc       = 1'b0;
    regDst      = 1'b0;
    memWrite    = 1'b0;
    memRead     = 1'b0;
    isJump      = 1'b0;
    link        = 1'b0;
    byteEnable  = 4'b1111;
    extendedMem = extNone;
    case (cpuState)
      fetchS: begin
        memRead = 1'b1;
        pcWrite = 1'b1;
        pcSrc   = branchDelay;
        // PC + 4 unless a redirect is pending
        if (!branchDelay) begin
          aluSrcB = 2'b01;
        end
      end
      stallS: memRead = 1'b1;
      decodeS: begin
        irWrite = 1'b1;
        irSel   = 1'b0;
        aluSrcB = 2'b11;
        if (instrClass inside {clsJ, clsJal}) begin
          extSel     = 1'b1;
          aluControl = aluPassB;
        end else begin
          aluControl = aluBranchTarget;
        end
      end
      exec1S: begin
        case (instrClass)
          clsAluReg: begin
            aluSrcA    = 1'b1;
            aluControl = aluFunct;
          end
          clsJr: begin
            aluSrcA    = 1'b1;
            aluControl = aluPassA;
          end
          // Return address written first
          clsJalr: begin
            aluSrcB  = 2'b01;
            regDst   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
          end
          clsLoad, clsStore, clsAluImm, clsLui: begin
            aluSrcA    = 1'b1;
            aluSrcB    = 2'b10;
            aluControl = immAluOp;
            extSel     = zeroExtend;
          end
          clsBranch: begin
            aluSrcA    = 1'b1;
            aluControl = immAluOp;
            aluSel     = 1'b1;
          end
          clsJ: begin
            isJump     = 1'b1;
            extSel     = 1'b1;
            aluSrcB    = 2'b11;
            aluControl = aluJumpTarget;
          end
          clsJal: begin
            aluSrcB  = 2'b01;
            memToReg = 1'b1;
            regWrite = 1'b1;
            link     = 1'b1;
          end
          default: ;
        endcase
      end
      exec2S: begin
        case (instrClass)
          clsAluReg: begin
            aluSel   = 1'b1;
            regDst   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
          end
          clsJalr: begin
            aluSrcA    = 1'b1;
            aluControl = aluPassA;
          end
          clsLoad: begin
            iorD        = 1'b1;
            aluSel      = 1'b1;
            memRead     = 1'b1;
            byteEnable  = sizeMask;
            extendedMem = loadExt;
          end
          clsStore: begin
            iorD       = 1'b1;
            aluSel     = 1'b1;
            memWrite   = 1'b1;
            byteEnable = sizeMask;
          end
          clsAluImm, clsLui: begin
            aluSel   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
          end
          clsJal: begin
            isJump     = 1'b1;
            extSel     = 1'b1;
            aluSrcB    = 2'b11;
            aluControl = aluJumpTarget;
          end
          default: ;
        endcase
      end
      exec3S: begin
        // Load writeback from the memory data register
        if (instrClass == clsLoad) begin
          regWrite    = 1'b1;
          extendedMem = loadExt;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/mipsControlUnit.sv ====
`timescale 1ns/100ps

module mipsControlUnit (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [controlPkg::instrWidth-1:0] instr,
  input  logic                              run,
  input  logic                              pcIsZero,
  input  logic                              waitRequest,
  input  logic                              outLsb,
  input  logic                              lessThan,
  output logic                              extSel,
  output logic                              irSel,
  output logic                              iorD,
  output logic                              aluSrcA,
  output logic [1:0]                        aluSrcB,
  output controlPkg::aluOpT                 aluControl,
  output logic                              aluSel,
  output logic                              irWrite,
  output logic                              pcWrite,
  output logic                              regWrite,
  output logic                              memToReg,
  output logic                              pcSrc,
  output logic                              regDst,
  output logic                              memWrite,
  output logic                              memRead,
  output logic                              isJump,
  output logic                              link,
  output logic [3:0]                        byteEnable,
  output controlPkg::memExtT                extendedMem,
  output logic                              active,
  output controlPkg::cpuStateT              cpuState,
  output logic                              branchDelay
);
  import controlPkg::*;

  instrClassT instrClass;
  logic [1:0] execCycles;
  branchKindT branchKind;
  aluOpT      immAluOp;
  logic       zeroExtend;
  accessSizeT accessSize;
  logic       signedLoad;

  instrClassifier i_classifier (
    .instr      (instr),
    .instrClass (instrClass),
    .execCycles (execCycles),
    .branchKind (branchKind),
    .immAluOp   (immAluOp),
    .zeroExtend (zeroExtend),
    .accessSize (accessSize),
    .signedLoad (signedLoad)
  );

  cycleSequencer i_sequencer (
    .clk         (clk),
    .rstN        (rstN),
    .run         (run),
    .pcIsZero    (pcIsZero),
    .waitRequest (waitRequest),
    .outLsb      (outLsb),
    .lessThan    (lessThan),
    .instrClass  (instrClass),
    .execCycles  (execCycles),
    .branchKind  (branchKind),
    .cpuState    (cpuState),
    .branchDelay (branchDelay)
  );

  controlSignalGen i_signalGen (
    .cpuState    (cpuState),
    .branchDelay (branchDelay),
    .instrClass  (instrClass),
    .immAluOp    (immAluOp),
    .zeroExtend  (zeroExtend),
    .accessSize  (accessSize),
    .signedLoad  (signedLoad),
    .extSel      (extSel),
    .irSel       (irSel),
    .iorD        (iorD),
    .aluSrcA     (aluSrcA),
    .aluSrcB     (aluSrcB),
    .aluControl  (aluControl),
    .aluSel      (aluSel),
    .irWrite     (irWrite),
    .pcWrite     (pcWrite),
    .regWrite    (regWrite),
    .memToReg    (memToReg),
    .pcSrc       (pcSrc),
    .regDst      (regDst),
    .memWrite    (memWrite),
    .memRead     (memRead),
    .isJump      (isJump),
    .link        (link),
    .byteEnable  (byteEnable),
    .extendedMem (extendedMem),
    .active      (active)
  );

endmodule

// ==== testbench/controlUnitAssertions.sv ====
`timescale 1ns/100ps

module controlUnitAssertions (
  input logic                 clk,
  input logic                 rstN,
  input controlPkg::cpuStateT cpuState,
  input logic                 memWrite,
  input logic                 irWrite
);
  import controlPkg::*;

  // State register only ever holds one of the seven codes
  stateDefined: assert property (@(posedge clk) disable iff (!rstN)
    cpuState inside {fetchS, decodeS, exec1S, exec2S, exec3S, haltedS, stallS})
    else $error("cpuState holds an undefined encoding %b", cpuState);

  // Store strobe belongs to the memory cycle
  writeInExec2: assert property (@(posedge clk) disable iff (!rstN)
    memWrite |-> cpuState == exec2S)
    else $error("memWrite is high while cpuState is %s", cpuState.name());

  irWriteInDecode: assert property (@(posedge clk) disable iff (!rstN)
    irWrite |-> cpuState == decodeS)
    else $error("irWrite is high while cpuState is %s", cpuState.name());

endmodule

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/100ps

module controlUnitTb;
  import controlPkg::*;

  localparam int numInstr   = 400;
  localparam int cycleLimit = numInstr * 12;

  logic        clk;
  logic        rstN;
  logic [31:0] instr;
  logic        run;
  logic        pcIsZero;
  logic        waitRequest;
  logic        outLsb;
  logic        lessThan;
  logic        extSel;
  logic        irSel;
  logic        iorD;
  logic        aluSrcA;
  logic [1:0]  aluSrcB;
  aluOpT       aluControl;
  logic        aluSel;
  logic        irWrite;
  logic        pcWrite;
  logic        regWrite;
  logic        memToReg;
  logic        pcSrc;
  logic        regDst;
  logic        memWrite;
  logic        memRead;
  logic        isJump;
  logic        link;
  logic [3:0]  byteEnable;
  memExtT      extendedMem;
  logic        active;
  cpuStateT    cpuState;
  logic        branchDelay;

  // Reference model of the sequencer
  cpuStateT   mState;
  logic       mDelay;
  instrClassT mClass;
  int         mCycles;
  branchKindT mKind;
  accessSizeT mSize;
  logic       mSigned;

  integer     seed = 22318;
  int         cycleCount = 0;
  int         instrCount = 0;
  int         execSpan = 0;
  int         expSpan = 0;
  cpuStateT   lastState = haltedS;
  opcodeT     opTable [20] = '{opRType, opRegimm, opJ, opJal, opBeq, opBne, opBlez, opBgtz,
                               opAddiu, opSlti, opAndi, opOri, opXori, opLui, opLb, opLh,
                               opLw, opLbu, opLhu, opSw};

  mipsControlUnit i_dut (
    .clk(clk), .rstN(rstN), .instr(instr), .run(run), .pcIsZero(pcIsZero),
    .waitRequest(waitRequest), .outLsb(outLsb), .lessThan(lessThan),
    .extSel(extSel), .irSel(irSel), .iorD(iorD), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
    .aluControl(aluControl), .aluSel(aluSel), .irWrite(irWrite), .pcWrite(pcWrite),
    .regWrite(regWrite), .memToReg(memToReg), .pcSrc(pcSrc), .regDst(regDst),
    .memWrite(memWrite), .memRead(memRead), .isJump(isJump), .link(link),
    .byteEnable(byteEnable), .extendedMem(extendedMem), .active(active),
    .cpuState(cpuState), .branchDelay(branchDelay)
  );

  bind mipsControlUnit controlUnitAssertions i_assertions (
    .clk(clk), .rstN(rstN), .cpuState(cpuState), .memWrite(memWrite), .irWrite(irWrite)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("STATUS: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Class, cycle count and access details from the instruction fields
  task automatic classify(input logic [31:0] word, output instrClassT cls, output int cycles,
                          output branchKindT kind, output accessSizeT size, output logic sgn);
    cls  = clsNop;
    kind = brEq;
    size = sizeWord;
    sgn  = 1'b0;
    case (word[31:26])
      opRType: begin
        if (word[5:0] == 6'b001000) cls = clsJr;
        else if (word[5:0] == 6'b001001) cls = clsJalr;
        else cls = clsAluReg;
      end
      opRegimm: begin
        if (word[20:16] == 5'd0) begin
          cls  = clsBranch;
          kind = brLtz;
        end else if (word[20:16] == 5'd1) begin
          cls  = clsBranch;
          kind = brGez;
        end
      end
      opBeq: begin
        cls  = clsBranch;
        kind = brEq;
      end
      opBne: begin
        cls  = clsBranch;
        kind = brNe;
      end
      opBgtz: begin
        cls  = clsBranch;
        kind = brGtz;
      end
      opBlez: begin
        cls  = clsBranch;
        kind = brLez;
      end
      opJ:   cls = clsJ;
      opJal: cls = clsJal;
      opAddiu, opSlti, opAndi, opOri, opXori: cls = clsAluImm;
      opLui: cls = clsLui;
      opLw:  cls = clsLoad;
      opLh, opLb: begin
        cls  = clsLoad;
        size = (word[26]) ? sizeHalf : sizeByte;
        sgn  = 1'b1;
      end
      opLhu, opLbu: begin
        cls  = clsLoad;
        size = (word[26]) ? sizeHalf : sizeByte;
      end
      opSw:  cls = clsStore;
      default: ;
    endcase
    if (cls == clsLoad) cycles = 3;
    else if (cls inside {clsJr, clsBranch, clsJ, clsNop}) cycles = 1;
    else cycles = 2;
  endtask

  // ALU code that an immediate, memory or branch opcode selects
  function automatic aluOpT immOpFor(input logic [5:0] op);
    aluOpT code;
    case (op)
      opRegimm:       code = aluSignTest;
      opBeq, opBne:   code = aluEq;
      opBgtz, opBlez: code = aluGtz;
      opSlti:         code = aluSlt;
      opAndi:         code = aluAnd;
      opOri:          code = aluOr;
      opXori:         code = aluXor;
      opLui:          code = aluLui;
      default:        code = aluAdd;
    endcase
    return code;
  endfunction

  function automatic logic [31:0] randomInstr();
    logic [31:0] word;
    int          pick;
    word        = $random(seed);
    pick        = $unsigned($random(seed)) % 20;
    word[31:26] = opTable[pick];
    pick        = $unsigned($random(seed)) % 4;
    // Bias the function and rt fields toward the jump and branch codes
    if (word[31:26] == opRType && pick < 2) word[5:0] = (pick == 1) ? 6'b001001 : 6'b001000;
    if (word[31:26] == opRegimm && pick < 3) word[20:16] = {4'b0000, pick[0]};
    return word;
  endfunction

  function automatic logic redirectTaken();
    logic taken;
    case (mKind)
      brEq:    taken = outLsb;
      brNe:    taken = !outLsb;
      brGtz:   taken = !outLsb;
      brLez:   taken = outLsb;
      brLtz:   taken = lessThan;
      default: taken = !lessThan;
    endcase
    return (mClass inside {clsJ, clsJal, clsJr, clsJalr}) || (mClass == clsBranch && taken);
  endfunction

  task automatic advanceModel();
    cpuStateT nxt;
    nxt = mState;
    if (mState != haltedS && pcIsZero) begin
      nxt = haltedS;
    end else begin
      case (mState)
        haltedS:        nxt = run ? fetchS : haltedS;
        fetchS, stallS: nxt = waitRequest ? stallS : decodeS;
        decodeS:        nxt = exec1S;
        exec1S:         nxt = (mCycles > 1) ? exec2S : fetchS;
        exec2S:         nxt = waitRequest ? exec2S : ((mCycles == 3) ? exec3S : fetchS);
        exec3S:         nxt = fetchS;
        default:        nxt = haltedS;
      endcase
    end
    if (mState == haltedS && run) mDelay = 1'b0;
    else if (nxt == fetchS && mState inside {exec1S, exec2S, exec3S}) mDelay = redirectTaken();
    if (nxt == decodeS) instrCount++;
    mState = nxt;
  endtask

  task automatic driveInputs();
    waitRequest = (($random(seed) & 3) == 0);
    pcIsZero    = ($unsigned($random(seed)) % 200 == 0);
    outLsb      = $random(seed);
    lessThan    = $random(seed);
    // A new word arrives with each fetch and stays until the next one
    if (mState == fetchS) instr = randomInstr();
    classify(instr, mClass, mCycles, mKind, mSize, mSigned);
  endtask

  task automatic checkOutputs();
    logic       isLoad;
    logic       isMem;
    logic [3:0] expEnable;
    logic [1:0] expExt;
    logic       expRegWrite;
    isLoad    = (mClass == clsLoad);
    isMem     = (isLoad || mClass == clsStore) && mState == exec2S;
    expEnable = 4'b1111;
    if (isMem && mSize == sizeHalf) expEnable = 4'b0011;
    else if (isMem && mSize == sizeByte) expEnable = 4'b0001;
    expExt = 2'b00;
    if (isLoad && mSigned && mState inside {exec2S, exec3S})
      expExt = (mSize == sizeHalf) ? 2'b11 : 2'b10;
    expRegWrite = (mState == exec2S && mClass inside {clsAluReg, clsAluImm, clsLui}) ||
                  (mState == exec3S && isLoad) ||
                  (mState == exec1S && mClass inside {clsJalr, clsJal});
    checkValue("cpuState", cpuState, mState);
    checkValue("branchDelay", branchDelay, mDelay);
    checkValue("active", active, mState != haltedS);
    checkValue("memRead", memRead, mState inside {fetchS, stallS} || (isLoad && isMem));
    checkValue("memWrite", memWrite, mClass == clsStore && mState == exec2S);
    checkValue("byteEnable", byteEnable, expEnable);
    checkValue("extendedMem", extendedMem, expExt);
    checkValue("regWrite", regWrite, expRegWrite);
    checkValue("irWrite", irWrite, mState == decodeS);
    checkValue("pcWrite", pcWrite, mState == fetchS);
    checkValue("pcSrc", pcSrc, mState == fetchS && mDelay);
    checkValue("isJump", isJump, (mClass == clsJ && mState == exec1S) ||
                                 (mClass == clsJal && mState == exec2S));
    checkValue("link", link, mClass == clsJal && mState == exec1S);
  endtask

  // Datapath selects and ALU code for the current state and class
  task automatic checkDatapath();
    logic       inExec1;
    logic       inExec2;
    logic       immForm;
    logic       expExtSel;
    logic       expSrcA;
    logic [1:0] expSrcB;
    aluOpT      expAlu;
    logic       expAluSel;
    inExec1   = (mState == exec1S);
    inExec2   = (mState == exec2S);
    immForm   = mClass inside {clsLoad, clsStore, clsAluImm, clsLui};
    expExtSel = (mState == decodeS && mClass inside {clsJ, clsJal}) ||
                (inExec1 && mClass == clsJ) ||
                (inExec1 && immForm && instr[31:26] inside {opAndi, opOri, opXori}) ||
                (inExec2 && mClass == clsJal);
    expSrcA   = (inExec1 && (immForm || mClass inside {clsAluReg, clsJr, clsBranch})) ||
                (inExec2 && mClass == clsJalr);
    expSrcB   = 2'b00;
    if (mState == fetchS && !mDelay) expSrcB = 2'b01;
    else if (mState == decodeS) expSrcB = 2'b11;
    else if (inExec1 && mClass inside {clsJalr, clsJal}) expSrcB = 2'b01;
    else if (inExec1 && immForm) expSrcB = 2'b10;
    else if ((inExec1 && mClass == clsJ) || (inExec2 && mClass == clsJal)) expSrcB = 2'b11;
    expAlu = aluAdd;
    if (mState == decodeS)
      expAlu = (mClass inside {clsJ, clsJal}) ? aluPassB : aluBranchTarget;
    else if (inExec1 && mClass == clsAluReg) expAlu = aluFunct;
    else if ((inExec1 && mClass == clsJr) || (inExec2 && mClass == clsJalr)) expAlu = aluPassA;
    else if (inExec1 && (immForm || mClass == clsBranch)) expAlu = immOpFor(instr[31:26]);
    else if ((inExec1 && mClass == clsJ) || (inExec2 && mClass == clsJal))
      expAlu = aluJumpTarget;
    expAluSel = (inExec1 && mClass == clsBranch) ||
                (inExec2 && (immForm || mClass == clsAluReg));
    checkValue("extSel", extSel, expExtSel);
    checkValue("irSel", irSel, mState != decodeS);
    checkValue("iorD", iorD, inExec2 && mClass inside {clsLoad, clsStore});
    checkValue("aluSrcA", aluSrcA, expSrcA);
    checkValue("aluSrcB", aluSrcB, expSrcB);
    checkValue("aluControl", aluControl, expAlu);
    checkValue("aluSel", aluSel, expAluSel);
    checkValue("memToReg", memToReg, (inExec1 && mClass inside {clsJalr, clsJal}) ||
                                     (inExec2 && mClass inside {clsAluReg, clsAluImm, clsLui}));
    checkValue("regDst", regDst, (inExec1 && mClass == clsJalr) ||
                                 (inExec2 && mClass == clsAluReg));
  endtask

  // Decode to fetch span seen on the DUT with one extra cycle per memory wait
  task automatic checkLatency();
    if (cpuState == decodeS) begin
      execSpan = 0;
      expSpan  = 1 + mCycles;
    end
    if (cpuState inside {decodeS, exec1S, exec2S, exec3S}) execSpan++;
    if (cpuState == exec2S && waitRequest) expSpan++;
    if (cpuState == fetchS && lastState inside {exec1S, exec2S, exec3S})
      checkValue("instruction latency", execSpan, expSpan);
    lastState = cpuState;
  endtask

  initial begin
    rstN        = 1'b0;
    instr       = 32'h0;
    run         = 1'b0;
    pcIsZero    = 1'b0;
    waitRequest = 1'b0;
    outLsb      = 1'b0;
    lessThan    = 1'b0;
    mState      = haltedS;
    mDelay      = 1'b0;
    classify(instr, mClass, mCycles, mKind, mSize, mSigned);
    repeat (8) @(posedge clk);
    #2;
    checkOutputs();
    checkDatapath();
    rstN = 1'b1;
    run  = 1'b1;
    while (instrCount < numInstr) begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > cycleLimit) begin
        $display("Timeout after %0d cycles with %0d instructions decoded",
                 cycleCount, instrCount);
        $display("STATUS: FAIL");
        $fatal(1, "Run did not finish within the cycle limit");
      end
      advanceModel();
      #2;
      driveInputs();
      #10;
      checkOutputs();
      checkDatapath();
      checkLatency();
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/controlPkg.sv
verilog/instrClassifier.sv
verilog/cycleSequencer.sv
verilog/controlSignalGen.sv
verilog/mipsControlUnit.sv
testbench/controlUnitAssertions.sv
testbench/controlUnitTb.sv
